/* hw/mdu_pkg.sv */
package mdu_pkg;

    // data word and reorder-buffer tag
    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_id_t;

    // multiply/divide operations
    typedef enum logic [1:0] {
        MDU_MUL  = 2'd0,  // low half of product
        MDU_MULH = 2'd1,  // high half, signed
        MDU_DIV  = 2'd2,
        MDU_REM  = 2'd3
    } mdu_op_e;

    // source operand, either present or waiting on a tag
    typedef struct packed {
        logic    rdy;
        rob_id_t tag;
        word_t   val;
    } src_t;

    // one dispatch lane
    typedef struct packed {
        mdu_op_e op;
        src_t    src0;
        src_t    src1;
        rob_id_t dst;
    } dispatch_t;

    // result bus beat, snooped and driven
    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   val;
    } cdb_t;

    // issue register toward the execute unit
    typedef struct packed {
        mdu_op_e op;
        word_t   a;
        word_t   b;
        rob_id_t dst;
    } mdu_req_t;

    // execute unit result
    typedef struct packed {
        rob_id_t dst;
        word_t   result;
    } mdu_resp_t;

endpackage

/* hw/iq_entry.sv */
`timescale 1ns/10ps

module iq_entry (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  logic                     write_i,
    input  mdu_pkg::dispatch_t       entry_i,
    input  mdu_pkg::cdb_t      [1:0] cdb_i,
    input  logic                     issue_i,
    output logic                     empty_o,
    output logic                     ready_o,
    output mdu_pkg::dispatch_t       entry_o
);

    logic               valid_q;
    mdu_pkg::dispatch_t entry_q;
    mdu_pkg::dispatch_t entry_d;

    // capture a bus value for a waiting operand
    function automatic mdu_pkg::src_t snoop(input mdu_pkg::src_t s,
                                            input mdu_pkg::cdb_t [1:0] bus);
        mdu_pkg::src_t r;
        r = s;
        for (int k = 0; k < 2; k++) begin
            if (!r.rdy && bus[k].valid && bus[k].tag == r.tag) begin
                r.rdy = 1'b1;
                r.val = bus[k].val;
            end
        end
        return r;
    endfunction

    // incoming instruction sees the same-cycle wakeup too
    always_comb begin
        entry_d      = write_i ? entry_i : entry_q;
        entry_d.src0 = snoop(entry_d.src0, cdb_i);
        entry_d.src1 = snoop(entry_d.src1, cdb_i);
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i || issue_i) begin
            valid_q <= 1'b0;
        end else if (write_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        entry_q <= entry_d;
    end

    assign empty_o = !valid_q;
    assign ready_o = valid_q && entry_q.src0.rdy && entry_q.src1.rdy;
    assign entry_o = entry_q;

    // allocation in the queue only ever picks a free slot
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (reset_i)
        write_i |-> !valid_q
    );

endmodule

/* hw/mdu_iq.sv */
`timescale 1ns/10ps

module mdu_iq #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  mdu_pkg::dispatch_t [1:0] p_entry_i,
    input  logic               [1:0] p_valid_i,
    output logic                     p_ready_o,
    input  mdu_pkg::cdb_t      [1:0] cdb_i,
    output logic                     ex_valid_o,
    input  logic                     ex_ready_i,
    output mdu_pkg::mdu_req_t        ex_req_o
);

    localparam int IW = $clog2(IQ_DEPTH);
    localparam int CW = $clog2(IQ_DEPTH + 1);

    logic               [IQ_DEPTH-1:0] slot_empty;
    logic               [IQ_DEPTH-1:0] slot_ready;
    logic               [IQ_DEPTH-1:0] slot_write;
    logic               [IQ_DEPTH-1:0] slot_issue;
    mdu_pkg::dispatch_t [IQ_DEPTH-1:0] slot_entry;
    logic               [IQ_DEPTH-1:0] free0_oh;
    logic               [IQ_DEPTH-1:0] free1_oh;

    logic              sel_any;
    logic     [IW-1:0] sel_idx;
    mdu_pkg::mdu_req_t sel_req;
    logic              load;
    logic              issue_fire;

    logic              ex_valid_q;
    mdu_pkg::mdu_req_t ex_req_q;
    logic     [CW-1:0] free_cnt_q;
    logic     [CW-1:0] free_nxt;
    logic              p_ready_q;

    // lane 0 fills from the bottom, lane 1 from the top
    always_comb begin
        free0_oh = '0;
        free1_oh = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (slot_empty[i]) begin
                free0_oh    = '0;
                free0_oh[i] = 1'b1;
            end
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (slot_empty[i]) begin
                free1_oh    = '0;
                free1_oh[i] = 1'b1;
            end
        end
    end

    // lowest ready slot wins
    always_comb begin
        sel_any = 1'b0;
        sel_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (slot_ready[i]) begin
                sel_any = 1'b1;
                sel_idx = IW'(i);
            end
        end
    end

    assign load       = !ex_valid_q || ex_ready_i;
    assign issue_fire = sel_any && load;

    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_slot
        logic lane1_hit;

        assign lane1_hit     = free1_oh[i] && p_valid_i[1];
        assign slot_write[i] = !flush_i && ((free0_oh[i] && p_valid_i[0]) || lane1_hit);
        assign slot_issue[i] = issue_fire && (sel_idx == IW'(i));

        iq_entry u_entry (
            .clk     (clk),
            .reset_i (reset_i),
            .flush_i (flush_i),
            .write_i (slot_write[i]),
            .entry_i (lane1_hit ? p_entry_i[1] : p_entry_i[0]),
            .cdb_i   (cdb_i),
            .issue_i (slot_issue[i]),
            .empty_o (slot_empty[i]),
            .ready_o (slot_ready[i]),
            .entry_o (slot_entry[i])
        );
    end

    always_comb begin
        sel_req.op  = slot_entry[sel_idx].op;
        sel_req.a   = slot_entry[sel_idx].src0.val;
        sel_req.b   = slot_entry[sel_idx].src1.val;
        sel_req.dst = slot_entry[sel_idx].dst;
    end

    // issue register
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ex_valid_q <= 1'b0;
        end else if (load) begin
            ex_valid_q <= sel_any;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            ex_req_q <= sel_req;
        end
    end

    assign ex_valid_o = ex_valid_q;
    assign ex_req_o   = ex_req_q;

    // free slots after this cycle's inserts and issue
    assign free_nxt = free_cnt_q - CW'(p_valid_i[0]) - CW'(p_valid_i[1]) + CW'(issue_fire);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            free_cnt_q <= CW'(IQ_DEPTH);
            p_ready_q  <= 1'b1;
        end else begin
            free_cnt_q <= free_nxt;
            p_ready_q  <= free_nxt >= CW'(2);
        end
    end

    assign p_ready_o = p_ready_q;

    a_dispatch_gated: assert property (
        @(posedge clk) disable iff (reset_i)
        (p_valid_i != 2'b00) |-> p_ready_o
    );

    a_req_held: assert property (
        @(posedge clk) disable iff (reset_i)
        (ex_valid_o && !ex_ready_i && !flush_i) |=> (ex_valid_o && $stable(ex_req_o))
    );

endmodule

/* hw/mdu_unit.sv */
`timescale 1ns/10ps

module mdu_unit (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                flush_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  mdu_pkg::mdu_req_t   req_i,
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output mdu_pkg::mdu_resp_t  res_o
);

    typedef enum logic [1:0] {
        IDLE,
        MUL,
        DIV,
        DONE
    } state_e;

    state_e               state_q;
    logic           [5:0] cnt_q;
    mdu_pkg::mdu_op_e     op_q;
    mdu_pkg::rob_id_t     dst_q;
    mdu_pkg::word_t       a_q;
    mdu_pkg::word_t       b_q;
    mdu_pkg::word_t       result_q;

    // multiply partial products
    logic signed   [48:0] pp_lo_q;
    logic signed   [47:0] pp_hi_q;
    logic signed   [63:0] hi_ext;
    logic signed   [63:0] lo_ext;
    logic signed   [63:0] prod;

    // divider datapath, magnitudes only
    logic signed   [32:0] rem_q;
    logic          [31:0] quo_q;
    logic          [31:0] dvs_q;
    logic signed   [32:0] rem_shift;
    logic signed   [32:0] rem_step;
    logic signed   [32:0] rem_fix;
    logic          [31:0] quo_out;
    logic          [31:0] rem_out;

    assign hi_ext = pp_hi_q;
    assign lo_ext = pp_lo_q;
    assign prod   = (hi_ext <<< 16) + lo_ext;

    assign rem_shift = {rem_q[31:0], quo_q[31]};
    assign rem_step  = rem_q[32] ? rem_shift + $signed({1'b0, dvs_q})
                                 : rem_shift - $signed({1'b0, dvs_q});
    assign rem_fix   = rem_q[32] ? rem_q + $signed({1'b0, dvs_q}) : rem_q;

    // sign fixup; most negative / -1 wraps back to the dividend on its own
    always_comb begin
        quo_out = (a_q[31] ^ b_q[31]) ? -quo_q : quo_q;
        rem_out = a_q[31] ? -rem_fix[31:0] : rem_fix[31:0];
        if (b_q == '0) begin
            quo_out = '1;
            rem_out = a_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_valid_i) begin
                        state_q <= (req_i.op inside {mdu_pkg::MDU_MUL, mdu_pkg::MDU_MULH})
                                   ? MUL : DIV;
                    end
                end
                MUL:     if (cnt_q == 6'd1) state_q <= DONE;
                DIV:     if (cnt_q == 6'd32) state_q <= DONE;
                DONE:    if (res_ready_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                cnt_q <= '0;
                op_q  <= req_i.op;
                dst_q <= req_i.dst;
                a_q   <= req_i.a;
                b_q   <= req_i.b;
                rem_q <= '0;
                quo_q <= req_i.a[31] ? -req_i.a : req_i.a;
                dvs_q <= req_i.b[31] ? -req_i.b : req_i.b;
            end
            MUL: begin
                cnt_q   <= cnt_q + 6'd1;
                pp_lo_q <= $signed(a_q) * $signed({1'b0, b_q[15:0]});
                pp_hi_q <= $signed(a_q) * $signed(b_q[31:16]);
                if (cnt_q == 6'd1) begin
                    result_q <= (op_q == mdu_pkg::MDU_MULH) ? prod[63:32] : prod[31:0];
                end
            end
            DIV: begin
                cnt_q <= cnt_q + 6'd1;
                if (cnt_q != 6'd32) begin
                    rem_q <= rem_step;
                    quo_q <= {quo_q[30:0], !rem_step[32]};
                end else begin
                    result_q <= (op_q == mdu_pkg::MDU_REM) ? rem_out : quo_out;
                end
            end
            default: ;
        endcase
    end

    assign req_ready_o   = state_q == IDLE;
    assign res_valid_o   = state_q == DONE;
    assign res_o.dst     = dst_q;
    assign res_o.result  = result_q;

    a_res_held: assert property (
        @(posedge clk) disable iff (reset_i)
        (res_valid_o && !res_ready_i && !flush_i) |=> (res_valid_o && $stable(res_o))
    );

endmodule

/* hw/commit_fifo.sv */
`timescale 1ns/10ps

module commit_fifo #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  mdu_pkg::mdu_resp_t in_data_i,
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output mdu_pkg::mdu_resp_t out_data_o
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    mdu_pkg::mdu_resp_t mem [FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr_q;
    logic [AW-1:0]      rd_ptr_q;
    logic [CW-1:0]      count_q;
    logic               push;
    logic               pop;

    assign in_ready_o  = count_q != CW'(FIFO_DEPTH);
    assign out_valid_o = count_q != '0;
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;
    assign out_data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_data_i;
        end
    end

    // circular pointers wrap at the depth rather than a power of two
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + AW'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + AW'(1);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + CW'(1);
                2'b01:   count_q <= count_q - CW'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // a push never lands on the unread head
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset_i)
        push |-> (count_q == '0 || wr_ptr_q != rd_ptr_q)
    );

endmodule

/* hw/mdu_backend.sv */
`timescale 1ns/10ps

module mdu_backend #(
    parameter int IQ_DEPTH   = 4,
    parameter int FIFO_DEPTH = 2
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  mdu_pkg::dispatch_t [1:0] p_entry_i,
    input  logic               [1:0] p_valid_i,
    output logic                     p_ready_o,
    input  mdu_pkg::cdb_t      [1:0] cdb_i,
    output mdu_pkg::cdb_t            cdb_o,
    input  logic                     cdb_ready_i
);

    logic               ex_valid;
    logic               ex_ready;
    mdu_pkg::mdu_req_t  ex_req;
    logic               res_valid;
    logic               res_ready;
    mdu_pkg::mdu_resp_t res;
    logic               out_valid;
    mdu_pkg::mdu_resp_t out_data;

    mdu_iq #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_iq (
        .clk        (clk),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .p_entry_i  (p_entry_i),
        .p_valid_i  (p_valid_i),
        .p_ready_o  (p_ready_o),
        .cdb_i      (cdb_i),
        .ex_valid_o (ex_valid),
        .ex_ready_i (ex_ready),
        .ex_req_o   (ex_req)
    );

    mdu_unit u_unit (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .req_valid_i (ex_valid),
        .req_ready_o (ex_ready),
        .req_i       (ex_req),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready),
        .res_o       (res)
    );

    commit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .in_valid_i  (res_valid),
        .in_ready_o  (res_ready),
        .in_data_i   (res),
        .out_valid_o (out_valid),
        .out_ready_i (cdb_ready_i),
        .out_data_o  (out_data)
    );

    // fifo head onto the result bus
    assign cdb_o.valid = out_valid;
    assign cdb_o.tag   = out_data.dst;
    assign cdb_o.val   = out_data.result;

endmodule

/* bench/mdu_model.svh */
// expected state per destination tag
logic               exp_pend [64];
mdu_pkg::mdu_op_e   exp_op   [64];
mdu_pkg::src_t      exp_src0 [64];
mdu_pkg::src_t      exp_src1 [64];
int                 outstanding;

// value rules of the four operations, special cases first
function automatic mdu_pkg::word_t expected_result(input mdu_pkg::mdu_op_e op,
                                                   input mdu_pkg::word_t a,
                                                   input mdu_pkg::word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] prod;
    logic               ovf;
    sa   = $signed(a);
    sb   = $signed(b);
    prod = sa * sb;
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
        mdu_pkg::MDU_MUL:  return prod[31:0];
        mdu_pkg::MDU_MULH: return prod[63:32];
        mdu_pkg::MDU_DIV:  return (b == '0) ? 32'hffff_ffff : ovf ? a : 32'(sa / sb);
        default:           return (b == '0) ? a : ovf ? 32'h0 : 32'(sa % sb);
    endcase
endfunction

function automatic void record_dispatch(input mdu_pkg::dispatch_t d);
    exp_pend[d.dst] = 1'b1;
    exp_op[d.dst]   = d.op;
    exp_src0[d.dst] = d.src0;
    exp_src1[d.dst] = d.src1;
    outstanding++;
endfunction

// a beat on cdb_i fills every recorded operand waiting on its tag
function automatic void apply_broadcast(input mdu_pkg::cdb_t b);
    for (int i = 0; i < 64; i++) begin
        if (exp_pend[i] && !exp_src0[i].rdy && exp_src0[i].tag == b.tag) begin
            exp_src0[i].rdy = 1'b1;
            exp_src0[i].val = b.val;
        end
        if (exp_pend[i] && !exp_src1[i].rdy && exp_src1[i].tag == b.tag) begin
            exp_src1[i].rdy = 1'b1;
            exp_src1[i].val = b.val;
        end
    end
endfunction

function automatic logic operands_present(input mdu_pkg::rob_id_t tag);
    return exp_src0[tag].rdy && exp_src1[tag].rdy;
endfunction

function automatic mdu_pkg::cdb_t expected_beat(input mdu_pkg::rob_id_t tag);
    mdu_pkg::cdb_t e;
    e.valid = 1'b1;
    e.tag   = tag;
    e.val   = expected_result(exp_op[tag], exp_src0[tag].val, exp_src1[tag].val);
    return e;
endfunction

function automatic void retire(input mdu_pkg::rob_id_t tag);
    exp_pend[tag] = 1'b0;
    outstanding--;
endfunction

function automatic void clear_model();
    for (int i = 0; i < 64; i++) begin
        exp_pend[i] = 1'b0;
    end
    outstanding = 0;
endfunction

/* bench/mdu_backend_tb.sv */
`timescale 1ns/10ps

module mdu_backend_tb;

    localparam int IQ_DEPTH   = 4;
    localparam int FIFO_DEPTH = 2;
    localparam int N_CORNER   = 4;
    localparam int N_READY    = 160;
    localparam int N_WAKE     = 160;
    localparam int N_PAIRS    = 8;
    localparam int N_BP       = 160;
    localparam int N_FLUSH    = 40;
    localparam int ROUNDS     = 3;
    localparam int N_TOTAL    = N_CORNER + N_READY + N_WAKE + 2 * N_PAIRS + N_BP
                                + ROUNDS * N_FLUSH;
    localparam int LIMIT      = N_TOTAL * 40 + 1000;

    logic                     clk;
    logic                     reset_i;
    logic                     flush_i;
    mdu_pkg::dispatch_t [1:0] p_entry_i;
    logic               [1:0] p_valid_i;
    logic                     p_ready_o;
    mdu_pkg::cdb_t      [1:0] cdb_i;
    mdu_pkg::cdb_t            cdb_o;
    logic                     cdb_ready_i;

    // stimulus knobs in percent per cycle
    int   disp_pct;
    int   wait_pct;
    int   bcast_pct;
    logic bp_mode;

    int               to_send;
    int               ready_left;
    int               dst_next;
    int               errors;
    int               checks;
    int               results;
    int               sent;
    int               test_err0;
    int               test_res0;
    logic             ready_seen_low;
    mdu_pkg::rob_id_t last_tag;
    mdu_pkg::dispatch_t scripted [$];

    // external producers live on tags 32..63 and dispatched results on 0..31
    logic [63:0]    prod_pend;
    mdu_pkg::word_t prod_val [64];

    `include "mdu_model.svh"

    mdu_backend #(
        .IQ_DEPTH   (IQ_DEPTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .p_entry_i   (p_entry_i),
        .p_valid_i   (p_valid_i),
        .p_ready_o   (p_ready_o),
        .cdb_i       (cdb_i),
        .cdb_o       (cdb_o),
        .cdb_ready_i (cdb_ready_i)
    );

    always #4 clk = ~clk;

    function automatic mdu_pkg::word_t rand_word();
        // corner values show up often
        case ($urandom % 8)
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    function automatic int slots_in_use();
        int n;
        n = 0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!dut_i.u_iq.slot_empty[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic mdu_pkg::src_t new_src();
        mdu_pkg::src_t s;
        logic    [5:0] t;
        if ($urandom % 100 < wait_pct) begin
            t = 6'd32 + 6'($urandom % 32);
            if (!prod_pend[t]) begin
                prod_pend[t] = 1'b1;
                prod_val[t]  = rand_word();
            end
            s.rdy = 1'b0;
            s.tag = t;
            // junk until the snooped value replaces it
            s.val = $urandom;
        end else begin
            s.rdy = 1'b1;
            s.tag = 6'($urandom);
            s.val = rand_word();
        end
        return s;
    endfunction

    function automatic mdu_pkg::rob_id_t alloc_dst();
        while (exp_pend[dst_next]) begin
            dst_next = (dst_next + 1) % 32;
        end
        alloc_dst = 6'(dst_next);
        dst_next  = (dst_next + 1) % 32;
    endfunction

    function automatic mdu_pkg::dispatch_t new_instr();
        mdu_pkg::dispatch_t d;
        d.op   = mdu_pkg::mdu_op_e'(2'($urandom % 4));
        d.src0 = new_src();
        d.src1 = new_src();
        d.dst  = alloc_dst();
        return d;
    endfunction

    // divide corners that random operands hit only rarely
    task automatic queue_corner_cases();
        mdu_pkg::dispatch_t d;
        for (int i = 0; i < N_CORNER; i++) begin
            d.op       = (i % 2 == 1) ? mdu_pkg::MDU_REM : mdu_pkg::MDU_DIV;
            d.src0.rdy = 1'b1;
            d.src0.tag = '0;
            d.src0.val = (i < 2) ? 32'h8000_0000 : rand_word();
            d.src1.rdy = 1'b1;
            d.src1.tag = '0;
            d.src1.val = (i < 2) ? 32'hffff_ffff : 32'h0000_0000;
            d.dst      = alloc_dst();
            scripted.push_back(d);
        end
    endtask

    task automatic check_cdb(input mdu_pkg::cdb_t got, input mdu_pkg::cdb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED cdb_o got %h expected %h (tag %0d)", got, exp, exp.tag);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED p_ready_o got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic take_result(input mdu_pkg::cdb_t got);
        results++;
        last_tag = got.tag;
        if (!exp_pend[got.tag]) begin
            errors++;
            $display("result for tag %0d arrived with nothing outstanding on it", got.tag);
        end else if (!operands_present(got.tag)) begin
            errors++;
            $display("tag %0d completed before its operands were broadcast", got.tag);
            retire(got.tag);
        end else begin
            check_cdb(got, expected_beat(got.tag));
            retire(got.tag);
        end
    endtask

    task automatic next_ready();
        if (flush_i) begin
            cdb_ready_i = 1'b0;
        end else if (!bp_mode) begin
            cdb_ready_i = 1'b1;
        end else begin
            // alternating stretches where long low ones fill the fifo
            if (ready_left == 0) begin
                cdb_ready_i = !cdb_ready_i;
                ready_left  = cdb_ready_i ? 1 + $urandom % 6 : 1 + $urandom % 24;
            end
            ready_left--;
        end
    endtask

    task automatic broadcast();
        mdu_pkg::cdb_t [1:0] b;
        int                  t;
        b = '0;
        for (int k = 0; k < 2; k++) begin
            if ($urandom % 100 < bcast_pct) begin
                t = 32 + $urandom % 32;
                for (int n = 0; n < 32 && !b[k].valid; n++) begin
                    if (prod_pend[t]) begin
                        b[k].valid   = 1'b1;
                        b[k].tag     = 6'(t);
                        b[k].val     = prod_val[t];
                        prod_pend[t] = 1'b0;
                        apply_broadcast(b[k]);
                    end
                    t = (t == 63) ? 32 : t + 1;
                end
            end
        end
        cdb_i = b;
    endtask

    // one clock entered and left on a falling edge
    task automatic cycle();
        logic         [1:0] v;
        mdu_pkg::dispatch_t d;
        check_ready(p_ready_o, slots_in_use() <= IQ_DEPTH - 2);
        if (!p_ready_o) begin
            ready_seen_low = 1'b1;
        end
        next_ready();
        if (cdb_o.valid && cdb_ready_i) begin
            take_result(cdb_o);
        end
        v = 2'b00;
        for (int k = 0; k < 2; k++) begin
            if (p_ready_o && !flush_i && scripted.size() > 0) begin
                d = scripted.pop_front();
            end else if (p_ready_o && !flush_i && to_send > 0 && $urandom % 100 < disp_pct) begin
                d = new_instr();
                to_send--;
            end else begin
                continue;
            end
            record_dispatch(d);
            p_entry_i[k] = d;
            v[k]         = 1'b1;
            sent++;
        end
        p_valid_i = v;
        broadcast();
        @(negedge clk);
    endtask

    task automatic run_stream(input int n);
        to_send = n;
        while (to_send > 0 || outstanding > 0) begin
            cycle();
        end
        // idle tail catches duplicate beats
        repeat (12) cycle();
    endtask

    task automatic ooo_pair();
        mdu_pkg::dispatch_t older;
        mdu_pkg::dispatch_t younger;
        int                 seen;
        bcast_pct  = 0;
        wait_pct   = 100;
        older.op   = mdu_pkg::mdu_op_e'(2'($urandom % 4));
        older.src0 = new_src();
        wait_pct   = 0;
        older.src1 = new_src();
        older.dst  = alloc_dst();
        younger    = new_instr();
        scripted.push_back(older);
        scripted.push_back(younger);
        seen = results;
        while (results == seen) begin
            cycle();
        end
        if (last_tag != younger.dst) begin
            errors++;
            $display("younger tag %0d did not finish ahead of waiting tag %0d",
                     younger.dst, older.dst);
        end
        bcast_pct = 50;
        run_stream(0);
    endtask

    task automatic flush_round(input int n);
        int hold;
        hold    = 1 + $urandom % 3;
        to_send = n;
        while (to_send > n / 2) begin
            cycle();
        end
        repeat ($urandom % 8) cycle();
        flush_i = 1'b1;
        clear_model();
        repeat (hold) cycle();
        flush_i = 1'b0;
        checks++;
        if (cdb_o.valid !== 1'b0) begin
            errors++;
            $display("FAILED cdb_o.valid got %h expected %h after flush", cdb_o.valid, 1'b0);
        end
        run_stream(to_send);
    endtask

    task automatic end_test(input string name);
        if (outstanding != 0) begin
            errors++;
            $display("%0d results still missing at the end of %s", outstanding, name);
        end
        if (errors == test_err0) begin
            $display("test %s: ok, %0d results", name, results - test_res0);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
        test_res0 = results;
    endtask

    initial begin
        void'($urandom(32'he0f8));
        clk            = 1'b0;
        reset_i        = 1'b1;
        flush_i        = 1'b0;
        p_entry_i      = '0;
        p_valid_i      = 2'b00;
        cdb_i          = '0;
        cdb_ready_i    = 1'b0;
        bp_mode        = 1'b0;
        ready_seen_low = 1'b0;
        prod_pend      = '0;
        last_tag       = '0;
        ready_left     = 0;
        dst_next       = 0;
        errors         = 0;
        checks         = 0;
        results        = 0;
        sent           = 0;
        test_err0      = 0;
        test_res0      = 0;
        clear_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        disp_pct  = 70;
        wait_pct  = 0;
        bcast_pct = 0;
        queue_corner_cases();
        run_stream(N_READY);
        end_test("ready operands");

        disp_pct  = 60;
        wait_pct  = 50;
        bcast_pct = 30;
        run_stream(N_WAKE);
        end_test("wakeup");

        repeat (N_PAIRS) ooo_pair();
        end_test("out-of-order issue");

        bp_mode        = 1'b1;
        ready_seen_low = 1'b0;
        disp_pct       = 90;
        wait_pct       = 25;
        bcast_pct      = 40;
        run_stream(N_BP);
        if (!ready_seen_low) begin
            errors++;
            $display("p_ready_o never dropped while results were held back");
        end
        bp_mode = 1'b0;
        end_test("back-pressure");

        disp_pct  = 80;
        wait_pct  = 30;
        bcast_pct = 40;
        repeat (ROUNDS) flush_round(N_FLUSH);
        end_test("flush");

        $display("summary: %0d dispatched, %0d results, %0d checks, %0d errors",
                 sent, results, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog sized from the instruction count
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* files.f */
+incdir+bench
hw/mdu_pkg.sv
hw/iq_entry.sv
hw/mdu_iq.sv
hw/mdu_unit.sv
hw/commit_fifo.sv
hw/mdu_backend.sv
bench/mdu_backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then scan the log for the failure banner
verilator --binary --timing --assert -Wno-fatal --top-module mdu_backend_tb \
    -f files.f -o mdu_sim > build.log 2>&1 \
    && ./obj_dir/mdu_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log \
    && { echo "simulation failed"; exit 1; } \
    || { echo "simulation finished cleanly"; exit 0; }
